// ==== verilog/mex_pkg.sv ====
package mex_pkg;

    // producer tag carried with each waiting operand
    localparam int tag_w = 4;

    // operand value width
    localparam int val_w = 16;

    // modifiable part of one entry
    // layout from the top: wake, tag, value
    localparam int m_w = 1 + tag_w + val_w;

    // field positions inside a modifiable part
    localparam int wake_pos = m_w - 1;
    localparam int tag_lsb = val_w;

    // queue depth used by the top level unless overridden
    localparam int def_q_length = 8;

    // width of the opaque decoded-instruction bits
    localparam int def_n_width = 16;

    // bits needed to address depth slots, never less than one
    // also used with depth + 1 to size an occupancy count
    function automatic int ptr_w_of(input int depth);
        int w;
        w = 1;
        while ((1 << w) < depth) begin
            w = w + 1;
        end
        return w;
    endfunction

endpackage

// ==== verilog/queue_ptr_ctrl.sv ====
module queue_ptr_ctrl #(
    parameter int q_length = mex_pkg::def_q_length
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     wr,
    input  logic                                     rd,
    input  logic                                     clr,
    output logic [mex_pkg::ptr_w_of(q_length)-1:0]   wr_slot,
    output logic [mex_pkg::ptr_w_of(q_length)-1:0]   rd_slot,
    output logic [q_length-1:0]                      occ_mask,
    output logic                                     full,
    output logic                                     empty
);
    import mex_pkg::*;

    localparam int ptr_w = ptr_w_of(q_length);
    // count has to reach q_length itself
    localparam int cnt_w = ptr_w_of(q_length + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(q_length - 1);

    logic [cnt_w-1:0]    cnt_q;
    logic [q_length-1:0] occ_next;
    logic                wr_ok;
    logic                rd_ok;

    // step with wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == last_slot) ? '0 : p + 1'b1;
    endfunction

    // accepted strobes, full blocks a write even alongside a read
    assign wr_ok = wr & ~full;
    assign rd_ok = rd & ~empty;

    assign full  = (cnt_q == cnt_w'(q_length));
    assign empty = (cnt_q == '0);

    // slot bookkeeping
    // a written slot is never the head slot unless the queue is empty
    always_comb begin
        occ_next = occ_mask;
        if (rd_ok) begin
            occ_next[rd_slot] = 1'b0;
        end
        if (wr_ok) begin
            occ_next[wr_slot] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_slot  <= '0;
            rd_slot  <= '0;
            cnt_q    <= '0;
            occ_mask <= '0;
        end else if (clr) begin
            // clear wins over everything else this edge
            wr_slot  <= '0;
            rd_slot  <= '0;
            cnt_q    <= '0;
            occ_mask <= '0;
        end else begin
            if (wr_ok) begin
                wr_slot <= next_ptr(wr_slot);
            end
            if (rd_ok) begin
                rd_slot <= next_ptr(rd_slot);
            end
            case ({wr_ok, rd_ok})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            occ_mask <= occ_next;
        end
    end

endmodule

// ==== verilog/queue_nm.sv ====
module queue_nm #(
    parameter int q_length = mex_pkg::def_q_length,
    parameter int n_width  = mex_pkg::def_n_width
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr,
    input  logic [mex_pkg::ptr_w_of(q_length)-1:0] wr_slot,
    input  logic [mex_pkg::ptr_w_of(q_length)-1:0] rd_slot,
    input  logic [q_length-1:0]                    occ_mask,
    input  logic [mex_pkg::m_w-1:0]                m_din,
    input  logic [n_width-1:0]                     n_din,
    input  logic [mex_pkg::m_w*q_length-1:0]       new_m_vector,
    input  logic [q_length-1:0]                    modify_vector,
    input  logic                                   full,
    output logic [mex_pkg::m_w*q_length-1:0]       old_m_vector,
    output logic [mex_pkg::m_w-1:0]                dout_m,
    output logic [n_width-1:0]                     dout_n
);
    import mex_pkg::*;

    localparam int ptr_w = ptr_w_of(q_length);
    // tag and value without the wake bit
    localparam int tv_w = m_w - 1;

    // wake bits per slot, kept apart so they come up cleared
    logic [q_length-1:0] wake_q;
    // tag and value per slot
    logic [tv_w-1:0]     tv_q [q_length];
    // opaque decoded bits per slot
    logic [n_width-1:0]  n_q  [q_length];

    logic                wr_ok;
    logic [q_length-1:0] wr_sel;
    logic [q_length-1:0] mod_sel;

    // same acceptance rule as the pointer block
    assign wr_ok = wr & ~full;

    // one-hot write select
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            wr_sel[i] = wr_ok && (wr_slot == ptr_w'(i));
        end
    end

    // only live entries may be modified in place
    assign mod_sel = modify_vector & occ_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_q <= '0;
        end else begin
            for (int i = 0; i < q_length; i++) begin
                if (wr_sel[i]) begin
                    wake_q[i] <= m_din[wake_pos];
                end else if (mod_sel[i]) begin
                    wake_q[i] <= new_m_vector[i*m_w + wake_pos];
                end
            end
        end
    end

    // payload side
    // a slot being written is free, so write and modify never meet
    always_ff @(posedge clk) begin
        for (int i = 0; i < q_length; i++) begin
            if (wr_sel[i]) begin
                tv_q[i] <= m_din[tv_w-1:0];
                n_q[i]  <= n_din;
            end else if (mod_sel[i]) begin
                tv_q[i] <= new_m_vector[i*m_w +: tv_w];
            end
        end
    end

    // flat view of every modifiable part for the wakeup logic
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            old_m_vector[i*m_w +: m_w] = {wake_q[i], tv_q[i]};
        end
    end

    // head entry, meaningless while empty
    assign dout_m = {wake_q[rd_slot], tv_q[rd_slot]};
    assign dout_n = n_q[rd_slot];

endmodule

// ==== verilog/operand_wakeup.sv ====
module operand_wakeup #(
    parameter int q_length = mex_pkg::def_q_length
) (
    input  logic                             bcast_valid,
    input  logic [mex_pkg::tag_w-1:0]        bcast_tag,
    input  logic [mex_pkg::val_w-1:0]        bcast_val,
    input  logic [mex_pkg::m_w*q_length-1:0] old_m_vector,
    input  logic                             in_wake,
    input  logic [mex_pkg::tag_w-1:0]        in_tag,
    input  logic [mex_pkg::val_w-1:0]        in_val,
    output logic [mex_pkg::m_w*q_length-1:0] new_m_vector,
    output logic [q_length-1:0]              modify_vector,
    output logic [mex_pkg::m_w-1:0]          m_din
);
    import mex_pkg::*;

    logic [m_w-1:0] in_m;

    // broadcast hits a sleeping operand waiting on that tag
    // operands already awake are left alone
    function automatic logic wake_hit(
        input logic             valid,
        input logic [tag_w-1:0] tag,
        input logic [m_w-1:0]   m
    );
        return valid && !m[wake_pos] && (m[tag_lsb +: tag_w] == tag);
    endfunction

    // woken copy keeps the tag, takes the broadcast value
    function automatic logic [m_w-1:0] wake_fill(
        input logic [m_w-1:0]   m,
        input logic [val_w-1:0] val
    );
        return {1'b1, m[tag_lsb +: tag_w], val};
    endfunction

    // waiting entries
    // occupancy is applied later by the storage
    always_comb begin
        new_m_vector  = old_m_vector;
        modify_vector = '0;
        for (int i = 0; i < q_length; i++) begin
            if (wake_hit(bcast_valid, bcast_tag, old_m_vector[i*m_w +: m_w])) begin
                modify_vector[i]           = 1'b1;
                new_m_vector[i*m_w +: m_w] = wake_fill(old_m_vector[i*m_w +: m_w], bcast_val);
            end
        end
    end

    // incoming operand, woken on entry when the broadcast matches
    assign in_m = {in_wake, in_tag, in_val};

    always_comb begin
        if (wake_hit(bcast_valid, bcast_tag, in_m)) begin
            m_din = wake_fill(in_m, bcast_val);
        end else begin
            // no match, enters as given
            m_din = in_m;
        end
    end

endmodule

// ==== verilog/mem_ex_queued_latches.sv ====
module mem_ex_queued_latches #(
    parameter int q_length = mex_pkg::def_q_length,
    parameter int n_width  = mex_pkg::def_n_width
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // memory stage side
    input  logic                      wr,
    input  logic                      in_wake,
    input  logic [mex_pkg::tag_w-1:0] in_tag,
    input  logic [mex_pkg::val_w-1:0] in_val,
    input  logic [n_width-1:0]        in_n,
    // execute stage side
    input  logic                      rd,
    input  logic                      clr,
    // result broadcast
    input  logic                      bcast_valid,
    input  logic [mex_pkg::tag_w-1:0] bcast_tag,
    input  logic [mex_pkg::val_w-1:0] bcast_val,
    output logic                      full,
    output logic                      empty,
    output logic                      out_wake,
    output logic [mex_pkg::tag_w-1:0] out_tag,
    output logic [mex_pkg::val_w-1:0] out_val,
    output logic [n_width-1:0]        out_n
);
    import mex_pkg::*;

    localparam int ptr_w = ptr_w_of(q_length);

    logic [ptr_w-1:0]        wr_slot;
    logic [ptr_w-1:0]        rd_slot;
    logic [q_length-1:0]     occ_mask;
    logic [m_w*q_length-1:0] old_m_vector;
    logic [m_w*q_length-1:0] new_m_vector;
    logic [q_length-1:0]     modify_vector;
    logic [m_w-1:0]          m_din;
    logic [m_w-1:0]          dout_m;

    // pointers, count and slot occupancy
    queue_ptr_ctrl #(.q_length(q_length)) u_ptr (
        .clk(clk), .rst_n(rst_n), .wr(wr), .rd(rd), .clr(clr),
        .wr_slot(wr_slot), .rd_slot(rd_slot), .occ_mask(occ_mask),
        .full(full), .empty(empty)
    );

    // entry storage
    queue_nm #(.q_length(q_length), .n_width(n_width)) u_store (
        .clk(clk), .rst_n(rst_n), .wr(wr), .wr_slot(wr_slot), .rd_slot(rd_slot),
        .occ_mask(occ_mask), .m_din(m_din), .n_din(in_n),
        .new_m_vector(new_m_vector), .modify_vector(modify_vector), .full(full),
        .old_m_vector(old_m_vector), .dout_m(dout_m), .dout_n(out_n)
    );

    // broadcast matching
    operand_wakeup #(.q_length(q_length)) u_wake (
        .bcast_valid(bcast_valid), .bcast_tag(bcast_tag), .bcast_val(bcast_val),
        .old_m_vector(old_m_vector), .in_wake(in_wake), .in_tag(in_tag), .in_val(in_val),
        .new_m_vector(new_m_vector), .modify_vector(modify_vector), .m_din(m_din)
    );

    // head operand fields
    assign out_wake = dout_m[wake_pos];
    assign out_tag  = dout_m[tag_lsb +: tag_w];
    assign out_val  = dout_m[0 +: val_w];

endmodule

// ==== dv/mem_ex_tb_table.svh ====
task automatic load_table();
    // fifo order, one head per read edge
    literal_row(op_push, 1'b0, 4'h1, 16'h0101, 4'h0, 16'h0, 1'b0, 1'b0, 1'b0, 4'h1, 16'h0101);
    model_row(op_push, 1'b0, 4'h2, 16'h0202, 4'h0, 16'h0);
    model_row(op_push, 1'b1, 4'h3, 16'h0303, 4'h0, 16'h0);
    model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    // pop while empty
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    // push and pop while empty, only the write happens
    literal_row(op_pushpop, 1'b0, 4'h7, 16'h0707, 4'h0, 16'h0, 1'b0, 1'b0, 1'b0, 4'h7, 16'h0707);
    model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    model_row(op_idle, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    // fill up, then push into a full queue
    for (int k = 0; k < q_len; k++) begin
        model_row(op_push, 1'b0, tag_w'(k + 4), 16'h1000 + val_w'(k), 4'h0, 16'h0);
    end
    literal_row(op_push, 1'b0, 4'hf, 16'h1f00, 4'h0, 16'h0, 1'b1, 1'b0, 1'b0, 4'h4, 16'h1000);
    // full with rd and wr, only the read happens
    model_row(op_pushpop, 1'b0, 4'hc, 16'h1c00, 4'h0, 16'h0);
    model_row(op_push, 1'b0, 4'hd, 16'h1d00, 4'h0, 16'h0);
    for (int k = 0; k < q_len; k++) begin
        model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    end
    literal_row(op_idle, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    // broadcast wakes every sleeping tag 5 entry
    model_row(op_push, 1'b0, 4'h5, 16'h0001, 4'h0, 16'h0);
    model_row(op_push, 1'b0, 4'h6, 16'h0002, 4'h0, 16'h0);
    model_row(op_push, 1'b0, 4'h5, 16'h0003, 4'h0, 16'h0);
    model_row(op_push, 1'b1, 4'h5, 16'h0044, 4'h0, 16'h0);
    literal_row(op_bcast, 1'b0, 4'h0, 16'h0, 4'h5, 16'hbeef, 1'b0, 1'b0, 1'b1, 4'h5, 16'hbeef);
    // second broadcast, woken entries stay
    literal_row(op_bcast, 1'b0, 4'h0, 16'h0, 4'h5, 16'hdead, 1'b0, 1'b0, 1'b1, 4'h5, 16'hbeef);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b0, 1'b0, 4'h6, 16'h0002);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b0, 1'b1, 4'h5, 16'hbeef);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b0, 1'b1, 4'h5, 16'h0044);
    model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    // incoming operand woken on entry, then one with no match
    literal_row(op_push_bc, 1'b0, 4'h9, 16'h0900, 4'h9, 16'hcafe, 1'b0, 1'b0, 1'b1, 4'h9,
                16'hcafe);
    model_row(op_push_bc, 1'b0, 4'ha, 16'h0a00, 4'h3, 16'h1234);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b0, 1'b0, 4'ha, 16'h0a00);
    literal_row(op_pushpop, 1'b1, 4'hb, 16'h0b00, 4'h0, 16'h0, 1'b0, 1'b0, 1'b1, 4'hb, 16'h0b00);
    model_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0);
    // clear with a write pending, then clear from full
    model_row(op_push, 1'b0, 4'h1, 16'h2001, 4'h0, 16'h0);
    model_row(op_push, 1'b0, 4'h2, 16'h2002, 4'h0, 16'h0);
    literal_row(op_clear_push, 1'b0, 4'h4, 16'h0404, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    literal_row(op_idle, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    for (int k = 0; k < q_len; k++) begin
        model_row(op_push, 1'b0, tag_w'(k), 16'h3000 + val_w'(k), 4'h0, 16'h0);
    end
    literal_row(op_clear, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
    literal_row(op_push, 1'b0, 4'h2, 16'h2222, 4'h0, 16'h0, 1'b0, 1'b0, 1'b0, 4'h2, 16'h2222);
    literal_row(op_pop, 1'b0, 4'h0, 16'h0, 4'h0, 16'h0, 1'b0, 1'b1, 1'b0, 4'h0, 16'h0);
endtask

// ==== dv/mem_ex_tb.sv ====
module mem_ex_tb;
    import mex_pkg::*;

    localparam int q_len = def_q_length;

    // operations a table row can apply
    localparam logic [2:0] op_idle       = 3'd0;
    localparam logic [2:0] op_push       = 3'd1;
    localparam logic [2:0] op_pop        = 3'd2;
    localparam logic [2:0] op_pushpop    = 3'd3;
    localparam logic [2:0] op_bcast      = 3'd4;
    localparam logic [2:0] op_push_bc    = 3'd5;
    localparam logic [2:0] op_clear      = 3'd6;
    localparam logic [2:0] op_clear_push = 3'd7;

    typedef struct packed {
        logic [2:0]       op;
        logic             in_wake;
        logic [tag_w-1:0] in_tag;
        logic [val_w-1:0] in_val;
        logic [tag_w-1:0] b_tag;
        logic [val_w-1:0] b_val;
        // set when the row carries literal expectations
        logic             lit;
        logic             exp_full;
        logic             exp_empty;
        logic             exp_wake;
        logic [tag_w-1:0] exp_tag;
        logic [val_w-1:0] exp_val;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wr;
    logic                   in_wake;
    logic [tag_w-1:0]       in_tag;
    logic [val_w-1:0]       in_val;
    logic [def_n_width-1:0] in_n;
    logic                   rd;
    logic                   clr;
    logic                   bcast_valid;
    logic [tag_w-1:0]       bcast_tag;
    logic [val_w-1:0]       bcast_val;
    logic                   full;
    logic                   empty;
    logic                   out_wake;
    logic [tag_w-1:0]       out_tag;
    logic [val_w-1:0]       out_val;
    logic [def_n_width-1:0] out_n;

    row_t                   rows[$];
    logic [def_n_width-1:0] n_vals[$];
    integer                 seed;
    int                     mismatches;
    int                     timeouts;

    // reference queue, circular
    logic                   mq_wake [q_len];
    logic [tag_w-1:0]       mq_tag  [q_len];
    logic [val_w-1:0]       mq_val  [q_len];
    logic [def_n_width-1:0] mq_n    [q_len];
    int                     mq_head;
    int                     mq_count;

    mem_ex_queued_latches #(.q_length(q_len), .n_width(def_n_width)) dut0 (
        .clk(clk), .rst_n(rst_n), .wr(wr), .in_wake(in_wake), .in_tag(in_tag),
        .in_val(in_val), .in_n(in_n), .rd(rd), .clr(clr), .bcast_valid(bcast_valid),
        .bcast_tag(bcast_tag), .bcast_val(bcast_val), .full(full), .empty(empty),
        .out_wake(out_wake), .out_tag(out_tag), .out_val(out_val), .out_n(out_n)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    `include "mem_ex_tb_table.svh"

    task automatic model_row(input logic [2:0] op, input logic w, input logic [tag_w-1:0] t,
                             input logic [val_w-1:0] v, input logic [tag_w-1:0] bt,
                             input logic [val_w-1:0] bv);
        rows.push_back({op, w, t, v, bt, bv, 1'b0, 1'b0, 1'b0, 1'b0, tag_w'(0), val_w'(0)});
    endtask

    task automatic literal_row(input logic [2:0] op, input logic w, input logic [tag_w-1:0] t,
                               input logic [val_w-1:0] v, input logic [tag_w-1:0] bt,
                               input logic [val_w-1:0] bv, input logic ef, input logic ee,
                               input logic ew, input logic [tag_w-1:0] et,
                               input logic [val_w-1:0] ev);
        rows.push_back({op, w, t, v, bt, bv, 1'b1, ef, ee, ew, et, ev});
    endtask

    // {wr, rd, clr, bcast_valid}
    function automatic logic [3:0] op_controls(input logic [2:0] op);
        case (op)
            op_push:       return 4'b1000;
            op_pop:        return 4'b0100;
            op_pushpop:    return 4'b1100;
            op_bcast:      return 4'b0001;
            op_push_bc:    return 4'b1001;
            op_clear:      return 4'b0010;
            op_clear_push: return 4'b1010;
            default:       return 4'b0000;
        endcase
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Fail at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_row(input int i);
        logic [3:0] ctl;
        ctl = op_controls(rows[i].op);
        wr          <= ctl[3];
        rd          <= ctl[2];
        clr         <= ctl[1];
        bcast_valid <= ctl[0];
        in_wake     <= rows[i].in_wake;
        in_tag      <= rows[i].in_tag;
        in_val      <= rows[i].in_val;
        in_n        <= n_vals[i];
        bcast_tag   <= rows[i].b_tag;
        bcast_val   <= rows[i].b_val;
    endtask

    task automatic drive_idle();
        wr          <= 1'b0;
        rd          <= 1'b0;
        clr         <= 1'b0;
        bcast_valid <= 1'b0;
    endtask

    // one edge of the reference queue
    task automatic model_step(input int i);
        logic [3:0]       ctl;
        logic             w;
        logic [val_w-1:0] v;
        logic             pop_ok;
        int               s;
        ctl = op_controls(rows[i].op);
        if (ctl[1]) begin
            mq_head  = 0;
            mq_count = 0;
        end else begin
            // sleeping entries with a matching tag wake up
            if (ctl[0]) begin
                for (int k = 0; k < mq_count; k++) begin
                    s = (mq_head + k) % q_len;
                    if (!mq_wake[s] && mq_tag[s] == rows[i].b_tag) begin
                        mq_wake[s] = 1'b1;
                        mq_val[s]  = rows[i].b_val;
                    end
                end
            end
            w = rows[i].in_wake;
            v = rows[i].in_val;
            if (ctl[0] && !w && rows[i].in_tag == rows[i].b_tag) begin
                w = 1'b1;
                v = rows[i].b_val;
            end
            // a pop needs a head that existed before this edge
            pop_ok = ctl[2] && mq_count > 0;
            // full blocks the push, decided before the pop
            if (ctl[3] && mq_count < q_len) begin
                s = (mq_head + mq_count) % q_len;
                mq_wake[s] = w;
                mq_tag[s]  = rows[i].in_tag;
                mq_val[s]  = v;
                mq_n[s]    = n_vals[i];
                mq_count++;
            end
            if (pop_ok) begin
                mq_head = (mq_head + 1) % q_len;
                mq_count--;
            end
        end
    endtask

    task automatic check_row(input int i);
        logic             ef;
        logic             ee;
        logic             ew;
        logic [tag_w-1:0] et;
        logic [val_w-1:0] ev;
        model_step(i);
        ef = (mq_count == q_len);
        ee = (mq_count == 0);
        ew = mq_wake[mq_head];
        et = mq_tag[mq_head];
        ev = mq_val[mq_head];
        if (rows[i].lit) begin
            // literal rows also cross-check the model
            check_value(64'({ef, ee}), 64'({rows[i].exp_full, rows[i].exp_empty}),
                        $sformatf("row %0d model flags vs table", i));
            if (!rows[i].exp_empty) begin
                check_value(64'({ew, et, ev}),
                            64'({rows[i].exp_wake, rows[i].exp_tag, rows[i].exp_val}),
                            $sformatf("row %0d model head vs table", i));
            end
            ef = rows[i].exp_full;
            ee = rows[i].exp_empty;
            ew = rows[i].exp_wake;
            et = rows[i].exp_tag;
            ev = rows[i].exp_val;
        end
        check_value(64'(full), 64'(ef), $sformatf("row %0d full", i));
        check_value(64'(empty), 64'(ee), $sformatf("row %0d empty", i));
        // head only means something while not empty
        if (!ee) begin
            check_value(64'(out_wake), 64'(ew), $sformatf("row %0d head wake", i));
            check_value(64'(out_tag), 64'(et), $sformatf("row %0d head tag", i));
            check_value(64'(out_val), 64'(ev), $sformatf("row %0d head value", i));
            check_value(64'(out_n), 64'(mq_n[mq_head]), $sformatf("row %0d head payload", i));
        end
    endtask

    task automatic wait_reset_release(input int max_cycles);
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was not released within %0d cycles", max_cycles);
        end
    endtask

    task automatic wait_until_empty(input int max_cycles);
        int n;
        n = 0;
        while (empty !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (empty !== 1'b1) begin
            timeouts++;
            $display("Timeout: queue did not report empty within %0d cycles", max_cycles);
        end
    endtask

    initial begin
        seed        = 74236;
        mismatches  = 0;
        timeouts    = 0;
        mq_head     = 0;
        mq_count    = 0;
        rst_n       = 1'b0;
        wr          = 1'b0;
        rd          = 1'b0;
        clr         = 1'b0;
        bcast_valid = 1'b0;
        in_wake     = 1'b0;
        in_tag      = '0;
        in_val      = '0;
        in_n        = '0;
        bcast_tag   = '0;
        bcast_val   = '0;
        load_table();
        // one random payload per row
        for (int i = 0; i < rows.size(); i++) begin
            n_vals.push_back(def_n_width'($random(seed)));
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_release(16);
        wait_until_empty(16);
        @(posedge clk);
        drive_row(0);
        // row i is sampled at this edge, row i+1 is driven at it
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            if (i + 1 < rows.size()) begin
                drive_row(i + 1);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_row(i);
        end
        wait_until_empty(16);
        $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+dv
verilog/mex_pkg.sv
verilog/queue_ptr_ctrl.sv
verilog/queue_nm.sv
verilog/operand_wakeup.sv
verilog/mem_ex_queued_latches.sv
dv/mem_ex_tb.sv

// ==== Bender.yml ====
package:
  name: mem_ex_queued_latches

sources:
  # design, in compile order
  - files:
      - verilog/mex_pkg.sv
      - verilog/queue_ptr_ctrl.sv
      - verilog/queue_nm.sv
      - verilog/operand_wakeup.sv
      - verilog/mem_ex_queued_latches.sv

  # testbench, with its stimulus table header
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mem_ex_tb.sv
